//--- design/spi_bus_pkg.sv
`default_nettype none

package spi_bus_pkg;

    // Word width bounds
    parameter int unsigned WORD_WIDTH_MIN = 8;
    parameter int unsigned WORD_WIDTH_MAX = 32;

    // Frame constants
    // Slave is selected while ss_n sits at this level
    parameter logic SS_ACTIVE = 1'b0;
    // Bit position where a new word starts
    parameter int unsigned BIT_POS_FIRST = 0;

    // Counter width that covers positions 0 .. word_width-1
    function automatic int unsigned bit_cnt_width(input int unsigned word_width);
        return $clog2(word_width);
    endfunction

endpackage

`default_nettype wire

//--- design/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // ------------------------------
    // Received word as it crosses into aclk
    // ------------------------------

    // Data is zero extended for narrower words
    typedef struct packed {
        logic [spi_bus_pkg::WORD_WIDTH_MAX-1:0] data;
        logic                                   tx_empty;
    } rx_word_t;

    // Default stream values
    parameter rx_word_t RX_WORD_IDLE = '{data: '0, tx_empty: 1'b0};

endpackage

`default_nettype wire

//--- design/spi_serial_engine.sv
`default_nettype none

module spi_serial_engine #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  SS_s,
    input  logic                  ss_n,
    input  logic                  sck,
    input  logic                  mosi,
    input  logic [WORD_WIDTH-1:0] tx_word,
    input  logic                  tx_loaded,
    output logic                  miso,
    output stream_pkg::rx_word_t  rx_word,
    output logic                  rx_toggle,
    output logic                  load_toggle
);
    import spi_bus_pkg::*;

    localparam int unsigned CNT_W = bit_cnt_width(WORD_WIDTH);
    localparam logic [CNT_W-1:0] LAST_POS = CNT_W'(WORD_WIDTH - 1);
    localparam logic [CNT_W-1:0] FIRST_POS = CNT_W'(BIT_POS_FIRST);

    logic                  frame_clr;
    logic [CNT_W-1:0]      rx_cnt;
    logic [CNT_W-1:0]      tx_cnt;
    logic [WORD_WIDTH-2:0] rx_shift;
    logic [WORD_WIDTH-1:0] tx_shift;
    logic                  word_tx_empty;

    // Deselect restarts the bit position
    assign frame_clr = SS_s | (ss_n != SS_ACTIVE);

    // ------------------------------
    // Receive side, falling sck
    // ------------------------------

    always_ff @(negedge sck or posedge frame_clr) begin
        if (frame_clr) begin
            rx_cnt <= '0;
        end else begin
            rx_cnt <= rx_cnt + 1'b1;
        end
    end

    always_ff @(negedge sck) begin
        rx_shift <= {rx_shift[WORD_WIDTH-3:0], mosi};
    end

    // Last bit completes the word
    always_ff @(negedge sck) begin
        if (rx_cnt == LAST_POS) begin
            rx_word.data     <= WORD_WIDTH_MAX'({rx_shift, mosi});
            rx_word.tx_empty <= word_tx_empty;
        end
    end

    // One flip per finished word
    always_ff @(negedge sck or posedge SS_s) begin
        if (SS_s) begin
            rx_toggle <= 1'b0;
        end else if (rx_cnt == LAST_POS) begin
            rx_toggle <= ~rx_toggle;
        end
    end

    // ------------------------------
    // Transmit side, rising sck
    // ------------------------------

    always_ff @(posedge sck or posedge frame_clr) begin
        if (frame_clr) begin
            tx_cnt <= '0;
        end else begin
            tx_cnt <= tx_cnt + 1'b1;
        end
    end

    // Load at word start, then MSB first
    always_ff @(posedge sck) begin
        if (tx_cnt == FIRST_POS) begin
            tx_shift      <= tx_loaded ? tx_word : '0;
            word_tx_empty <= ~tx_loaded;
        end else begin
            tx_shift <= {tx_shift[WORD_WIDTH-2:0], 1'b0};
        end
    end

    // Tells the aclk side its word was taken
    always_ff @(posedge sck or posedge SS_s) begin
        if (SS_s) begin
            load_toggle <= 1'b0;
        end else if (tx_cnt == FIRST_POS) begin
            load_toggle <= ~load_toggle;
        end
    end

    assign miso = tx_shift[WORD_WIDTH-1];

endmodule

`default_nettype wire

//--- design/rx_word_cdc.sv
`default_nettype none

module rx_word_cdc (
    input  logic                 aclk,
    input  logic                 SS_s,
    input  logic                 rx_toggle,
    input  stream_pkg::rx_word_t rx_word,
    output stream_pkg::rx_word_t rx_word_sync,
    output logic                 rx_word_strobe
);
    import stream_pkg::*;

    logic toggle_q1;
    logic toggle_q2;
    logic toggle_q3;
    logic toggle_change;

    // ------------------------------
    // Toggle synchronizer
    // ------------------------------

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            toggle_q1 <= 1'b0;
            toggle_q2 <= 1'b0;
            toggle_q3 <= 1'b0;
        end else begin
            toggle_q1 <= rx_toggle;
            toggle_q2 <= toggle_q1;
            toggle_q3 <= toggle_q2;
        end
    end

    // Either direction means a new word
    assign toggle_change = toggle_q2 ^ toggle_q3;

    // Word held steady in sck domain by now
    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            rx_word_sync <= RX_WORD_IDLE;
        end else if (toggle_change) begin
            rx_word_sync <= rx_word;
        end
    end

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            rx_word_strobe <= 1'b0;
        end else begin
            rx_word_strobe <= toggle_change;
        end
    end

endmodule

`default_nettype wire

//--- design/rx_stream_out.sv
`default_nettype none

module rx_stream_out #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  SS_s,
    input  stream_pkg::rx_word_t  rx_word_sync,
    input  logic                  rx_word_strobe,
    input  logic                  rx_ready,
    output logic [WORD_WIDTH-1:0] rx_data,
    output logic                  rx_tx_empty,
    output logic                  rx_valid,
    output logic                  overrun
);

    logic stalled;
    logic accept;

    // Held word not yet taken by the consumer
    assign stalled = rx_valid & ~rx_ready;
    assign accept  = rx_word_strobe & ~stalled;

    // ------------------------------
    // Output register
    // ------------------------------

    always_ff @(posedge aclk) begin
        if (accept) begin
            rx_data     <= rx_word_sync.data[WORD_WIDTH-1:0];
            rx_tx_empty <= rx_word_sync.tx_empty;
        end
    end

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            rx_valid <= 1'b0;
        end else if (accept) begin
            rx_valid <= 1'b1;
        end else if (rx_ready) begin
            rx_valid <= 1'b0;
        end
    end

    // Sticky until reset
    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            overrun <= 1'b0;
        end else if (rx_word_strobe && stalled) begin
            overrun <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- design/tx_word_stage.sv
`default_nettype none

module tx_word_stage #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  SS_s,
    input  logic [WORD_WIDTH-1:0] tx_data,
    input  logic                  tx_valid,
    input  logic                  load_toggle,
    output logic                  tx_ready,
    output logic [WORD_WIDTH-1:0] tx_word,
    output logic                  tx_loaded
);

    typedef enum logic [1:0] {
        TX_RST,
        TX_EMPTY,
        TX_LOADED
    } tx_state_t;

    tx_state_t state;
    tx_state_t state_next;
    logic      load_q1;
    logic      load_q2;
    logic      load_q3;
    logic      load_seen;

    // ------------------------------
    // Load toggle from sck domain
    // ------------------------------

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            load_q1 <= 1'b0;
            load_q2 <= 1'b0;
            load_q3 <= 1'b0;
        end else begin
            load_q1 <= load_toggle;
            load_q2 <= load_q1;
            load_q3 <= load_q2;
        end
    end

    assign load_seen = load_q2 ^ load_q3;

    // ------------------------------
    // State machine
    // ------------------------------

    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            state <= TX_RST;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        case (state)
            TX_RST:    state_next = TX_EMPTY;
            TX_EMPTY:  state_next = (tx_valid && tx_ready) ? TX_LOADED : TX_EMPTY;
            TX_LOADED: state_next = load_seen ? TX_EMPTY : TX_LOADED;
            default:   state_next = TX_RST;
        endcase
    end

    // Flags follow the next state so they line up with it
    always_ff @(posedge aclk or posedge SS_s) begin
        if (SS_s) begin
            tx_ready  <= 1'b0;
            tx_loaded <= 1'b0;
        end else begin
            tx_ready  <= (state_next == TX_EMPTY);
            tx_loaded <= (state_next == TX_LOADED);
        end
    end

    // Stays put while loaded
    always_ff @(posedge aclk) begin
        if (tx_valid && tx_ready) begin
            tx_word <= tx_data;
        end
    end

endmodule

`default_nettype wire

//--- design/spi_slave_top.sv
`default_nettype none

module spi_slave_top #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  SS_s,
    // SPI pins
    input  logic                  ss_n,
    input  logic                  sck,
    input  logic                  mosi,
    output logic                  miso,
    output logic                  miso_oe,
    // Received words
    output logic [WORD_WIDTH-1:0] rx_data,
    output logic                  rx_tx_empty,
    output logic                  rx_valid,
    input  logic                  rx_ready,
    output logic                  overrun,
    // Transmit words
    input  logic [WORD_WIDTH-1:0] tx_data,
    input  logic                  tx_valid,
    output logic                  tx_ready
);
    import spi_bus_pkg::*;
    import stream_pkg::*;

    rx_word_t              rx_word;
    rx_word_t              rx_word_sync;
    logic                  rx_toggle;
    logic                  rx_word_strobe;
    logic                  load_toggle;
    logic [WORD_WIDTH-1:0] tx_word;
    logic                  tx_loaded;

    // 8, 16 or 32 only
    if ((WORD_WIDTH < WORD_WIDTH_MIN) || (WORD_WIDTH > WORD_WIDTH_MAX) ||
        ((1 << bit_cnt_width(WORD_WIDTH)) != WORD_WIDTH)) begin : g_width_check
        $error("spi_slave_top: WORD_WIDTH %0d not supported", WORD_WIDTH);
    end

    // Drive miso only while selected
    assign miso_oe = (ss_n == SS_ACTIVE);

    // ------------------------------
    // sck domain
    // ------------------------------

    spi_serial_engine #(.WORD_WIDTH(WORD_WIDTH)) u_engine (
        .SS_s        (SS_s),
        .ss_n        (ss_n),
        .sck         (sck),
        .mosi        (mosi),
        .tx_word     (tx_word),
        .tx_loaded   (tx_loaded),
        .miso        (miso),
        .rx_word     (rx_word),
        .rx_toggle   (rx_toggle),
        .load_toggle (load_toggle)
    );

    // ------------------------------
    // aclk domain
    // ------------------------------

    rx_word_cdc u_rx_cdc (
        .aclk           (aclk),
        .SS_s           (SS_s),
        .rx_toggle      (rx_toggle),
        .rx_word        (rx_word),
        .rx_word_sync   (rx_word_sync),
        .rx_word_strobe (rx_word_strobe)
    );

    rx_stream_out #(.WORD_WIDTH(WORD_WIDTH)) u_rx_out (
        .aclk           (aclk),
        .SS_s           (SS_s),
        .rx_word_sync   (rx_word_sync),
        .rx_word_strobe (rx_word_strobe),
        .rx_ready       (rx_ready),
        .rx_data        (rx_data),
        .rx_tx_empty    (rx_tx_empty),
        .rx_valid       (rx_valid),
        .overrun        (overrun)
    );

    tx_word_stage #(.WORD_WIDTH(WORD_WIDTH)) u_tx_stage (
        .aclk        (aclk),
        .SS_s        (SS_s),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .load_toggle (load_toggle),
        .tx_ready    (tx_ready),
        .tx_word     (tx_word),
        .tx_loaded   (tx_loaded)
    );

endmodule

`default_nettype wire

//--- dv/spi_slave_assertions.sv
`default_nettype none

module spi_slave_assertions #(
    parameter int unsigned WORD_WIDTH = 8
) (
    input  logic                  aclk,
    input  logic                  SS_s,
    input  logic                  ss_n,
    input  logic                  miso_oe,
    input  logic [WORD_WIDTH-1:0] rx_data,
    input  logic                  rx_tx_empty,
    input  logic                  rx_valid,
    input  logic                  rx_ready,
    input  logic                  tx_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned failures = 0;

    // Held word does not move while the consumer stalls
    property rx_hold_stable;
        @(posedge aclk) disable iff (SS_s)
        (rx_valid && !rx_ready) |=> ($stable(rx_data) && $stable(rx_tx_empty));
    endproperty

    // Both streams quiet in reset and on release
    property quiet_after_reset;
        @(posedge aclk) (SS_s || $fell(SS_s)) |-> (!rx_valid && !tx_ready);
    endproperty

    property oe_follows_select;
        @(posedge aclk) miso_oe == !ss_n;
    endproperty

    a_rx_hold: assert property (rx_hold_stable)
        else begin
            failures++;
            $error("rx_data changed while rx_valid was held against rx_ready low");
        end

    a_reset_quiet: assert property (quiet_after_reset)
        else begin
            failures++;
            $error("rx_valid or tx_ready high during or right after reset");
        end

    a_oe_select: assert property (oe_follows_select)
        else begin
            failures++;
            $error("miso_oe does not follow ss_n");
        end

endmodule

bind spi_slave_top spi_slave_assertions #(.WORD_WIDTH(WORD_WIDTH)) u_sva (
    .aclk        (aclk),
    .SS_s        (SS_s),
    .ss_n        (ss_n),
    .miso_oe     (miso_oe),
    .rx_data     (rx_data),
    .rx_tx_empty (rx_tx_empty),
    .rx_valid    (rx_valid),
    .rx_ready    (rx_ready),
    .tx_ready    (tx_ready)
);

`default_nettype wire

//--- dv/spi_slave_tb.sv
`default_nettype none

module spi_slave_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import spi_bus_pkg::*;
    import stream_pkg::*;

    localparam int unsigned WORD_WIDTH     = 16;
    localparam int unsigned SCK_HALF       = 4;
    localparam int unsigned RESET_CYCLES   = 16;
    localparam int unsigned RX_LATENCY_MAX = 6;
    localparam int unsigned BREAK_BITS     = 5;
    localparam int unsigned NUM_ROWS       = 10;
    localparam int unsigned CYCLE_LIMIT    = NUM_ROWS * (WORD_WIDTH * 8 + 40) + 100;

    // One word on the bus and what should come of it
    typedef struct packed {
        logic [WORD_WIDTH-1:0] mosi_word;
        logic [WORD_WIDTH-1:0] tx_word;
        logic                  tx_load;
        logic                  stall;
        logic                  hold_ss;
        logic                  break_first;
        logic                  exp_tx_empty;
        logic [WORD_WIDTH-1:0] exp_miso;
        logic                  exp_overrun;
    } row_t;

    logic                  aclk;
    logic                  SS_s;
    logic                  ss_n;
    logic                  sck;
    logic                  mosi;
    logic                  miso;
    logic                  miso_oe;
    logic [WORD_WIDTH-1:0] rx_data;
    logic                  rx_tx_empty;
    logic                  rx_valid;
    logic                  rx_ready;
    logic                  overrun;
    logic [WORD_WIDTH-1:0] tx_data;
    logic                  tx_valid;
    logic                  tx_ready;

    row_t        rows[$];
    int          seed = 87;
    int unsigned cycle_count = 0;
    logic        held_valid;
    rx_word_t    held_word;

    spi_slave_top #(.WORD_WIDTH(WORD_WIDTH)) uut (
        .aclk        (aclk),
        .SS_s        (SS_s),
        .ss_n        (ss_n),
        .sck         (sck),
        .mosi        (mosi),
        .miso        (miso),
        .miso_oe     (miso_oe),
        .rx_data     (rx_data),
        .rx_tx_empty (rx_tx_empty),
        .rx_valid    (rx_valid),
        .rx_ready    (rx_ready),
        .overrun     (overrun),
        .tx_data     (tx_data),
        .tx_valid    (tx_valid),
        .tx_ready    (tx_ready)
    );

    initial begin
        aclk = 1'b0;
        forever #5 aclk = ~aclk;
    end

    // ------------------------------
    // Failure handling and checks
    // ------------------------------

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic rx_word_t make_rx_word(input logic [WORD_WIDTH-1:0] data,
                                              input logic tx_empty);
        rx_word_t word;
        word.data     = WORD_WIDTH_MAX'(data);
        word.tx_empty = tx_empty;
        return word;
    endfunction

    task automatic check_rx(input string name, input rx_word_t actual, input rx_word_t expected);
        if (actual !== expected) begin
            $display("error: %s 0x%h tx_empty 0x%h, expected 0x%h tx_empty 0x%h", name,
                     actual.data, actual.tx_empty, expected.data, expected.tx_empty);
            abort_run("received word mismatch");
        end
    endtask

    task automatic check_word(input string name, input logic [WORD_WIDTH-1:0] actual,
                              input logic [WORD_WIDTH-1:0] expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abort_run("word mismatch");
        end
    endtask

    task automatic check_flag(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("error: %s is 0x%h, expected 0x%h", name, actual, expected);
            abort_run("flag mismatch");
        end
    endtask

    // Watchdog
    initial begin
        forever begin
            @(posedge aclk);
            cycle_count++;
            if (cycle_count >= CYCLE_LIMIT) begin
                abort_run($sformatf("run did not finish within %0d aclk cycles", CYCLE_LIMIT));
            end
        end
    end

    always @(negedge aclk) begin
        if (uut.u_sva.failures != 0) begin
            abort_run("a stream assertion failed");
        end
    end

    // ------------------------------
    // Stimulus helpers
    // ------------------------------

    task automatic add_row(input logic load, input logic stall, input logic hold_ss,
                           input logic break_first, input logic exp_overrun);
        row_t row;
        row.mosi_word    = WORD_WIDTH'($random(seed));
        row.tx_word      = WORD_WIDTH'($random(seed));
        row.tx_load      = load;
        row.stall        = stall;
        row.hold_ss      = hold_ss;
        row.break_first  = break_first;
        // Master reads zeros when nothing was loaded
        row.exp_tx_empty = ~load;
        row.exp_miso     = load ? row.tx_word : '0;
        row.exp_overrun  = exp_overrun;
        rows.push_back(row);
    endtask

    task automatic load_tx(input logic [WORD_WIDTH-1:0] word);
        int unsigned waited;
        waited = 0;
        @(posedge aclk);
        #1;
        while (tx_ready !== 1'b1) begin
            waited++;
            if (waited > RX_LATENCY_MAX) begin
                abort_run("tx_ready stayed low although the transmit stage should be empty");
            end
            @(posedge aclk);
            #1;
        end
        tx_data  = word;
        tx_valid = 1'b1;
        @(posedge aclk);
        #1;
        tx_valid = 1'b0;
        tx_data  = '0;
        check_flag("tx_ready", tx_ready, 1'b0);
    endtask

    // Mode with sampling on falling sck, MSB first
    task automatic shift_word(input logic [WORD_WIDTH-1:0] mosi_word,
                              output logic [WORD_WIDTH-1:0] miso_word);
        int bit_idx;
        miso_word = '0;
        mosi      = mosi_word[WORD_WIDTH-1];
        for (bit_idx = WORD_WIDTH - 1; bit_idx >= 0; bit_idx--) begin
            repeat (SCK_HALF) @(posedge aclk);
            #1 sck = 1'b1;
            repeat (SCK_HALF) @(posedge aclk);
            #1;
            miso_word[bit_idx] = miso;
            sck = 1'b0;
            if (bit_idx > 0) begin
                #1 mosi = mosi_word[bit_idx-1];
            end
        end
    endtask

    // A few clocks, then deselect in mid word
    task automatic break_frame(input int unsigned num_bits);
        repeat (num_bits) begin
            repeat (SCK_HALF) @(posedge aclk);
            #1 sck = 1'b1;
            repeat (SCK_HALF) @(posedge aclk);
            #1 sck = 1'b0;
        end
        @(posedge aclk);
        #1 ss_n = ~SS_ACTIVE;
        @(posedge aclk);
        #1 ss_n = SS_ACTIVE;
    endtask

    task automatic wait_rx_event(input logic want_overrun);
        int unsigned cycles;
        cycles = 0;
        @(negedge aclk);
        while ((want_overrun ? overrun : rx_valid) !== 1'b1) begin
            cycles++;
            if (cycles > RX_LATENCY_MAX) begin
                if (want_overrun) begin
                    abort_run("overrun did not rise after a word arrived while stalled");
                end else begin
                    abort_run("rx_valid did not rise within 6 aclk cycles of the last sck edge");
                end
            end
            @(negedge aclk);
        end
    endtask

    // Consumer takes the held word, nothing follows it
    task automatic release_held();
        @(posedge aclk);
        #1 rx_ready = 1'b1;
        @(negedge aclk);
        check_flag("rx_valid", rx_valid, 1'b1);
        check_rx("rx_data", make_rx_word(rx_data, rx_tx_empty), held_word);
        @(negedge aclk);
        check_flag("rx_valid", rx_valid, 1'b0);
        held_valid = 1'b0;
    endtask

    task automatic run_row(input row_t row);
        logic [WORD_WIDTH-1:0] miso_word;
        rx_word_t              expected;
        expected = make_rx_word(row.mosi_word, row.exp_tx_empty);
        if (row.tx_load) begin
            load_tx(row.tx_word);
        end
        if (held_valid && !row.stall) begin
            release_held();
        end
        @(posedge aclk);
        #1 rx_ready = ~row.stall;
        if (ss_n != SS_ACTIVE) begin
            @(posedge aclk);
            #1 ss_n = SS_ACTIVE;
            @(negedge aclk);
            check_flag("miso_oe", miso_oe, 1'b1);
        end
        // Cut word must leave no trace in the next one
        if (row.break_first) begin
            break_frame(BREAK_BITS);
        end
        // Loaded word waits until the frame takes it
        if (row.tx_load) begin
            check_flag("tx_ready", tx_ready, 1'b0);
        end
        shift_word(row.mosi_word, miso_word);
        check_word("miso", miso_word, row.exp_miso);
        if (held_valid) begin
            wait_rx_event(1'b1);
            check_flag("rx_valid", rx_valid, 1'b1);
            check_rx("rx_data", make_rx_word(rx_data, rx_tx_empty), held_word);
        end else begin
            wait_rx_event(1'b0);
            check_rx("rx_data", make_rx_word(rx_data, rx_tx_empty), expected);
            if (row.stall) begin
                held_valid = 1'b1;
                held_word  = expected;
            end else begin
                @(negedge aclk);
                check_flag("rx_valid", rx_valid, 1'b0);
            end
        end
        check_flag("overrun", overrun, row.exp_overrun);
        check_flag("tx_ready", tx_ready, 1'b1);
        if (!row.hold_ss) begin
            @(posedge aclk);
            #1 ss_n = ~SS_ACTIVE;
            @(negedge aclk);
            check_flag("miso_oe", miso_oe, 1'b0);
        end
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------

    initial begin
        SS_s       = 1'b1;
        ss_n       = ~SS_ACTIVE;
        sck        = 1'b0;
        mosi       = 1'b0;
        rx_ready   = 1'b1;
        tx_data    = '0;
        tx_valid   = 1'b0;
        held_valid = 1'b0;
        held_word  = RX_WORD_IDLE;

        // load stall hold_ss break overrun
        add_row(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
        add_row(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, 1'b1, 1'b0, 1'b0);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
        add_row(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
        // Stall: first word held, second dropped
        add_row(1'b1, 1'b1, 1'b0, 1'b0, 1'b0);
        add_row(1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
        add_row(1'b1, 1'b0, 1'b0, 1'b0, 1'b1);
        add_row(1'b0, 1'b0, 1'b0, 1'b0, 1'b1);

        repeat (RESET_CYCLES) @(posedge aclk);
        check_flag("tx_ready", tx_ready, 1'b0);
        check_flag("rx_valid", rx_valid, 1'b0);
        check_flag("overrun", overrun, 1'b0);
        #1 SS_s = 1'b0;

        foreach (rows[i]) begin
            run_row(rows[i]);
        end

        repeat (4) @(posedge aclk);
        if (uut.u_sva.failures == 0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            abort_run("stream assertions reported failures");
        end
    end

endmodule

`default_nettype wire

//--- spi_slave.f
design/spi_bus_pkg.sv
design/stream_pkg.sv
design/spi_serial_engine.sv
design/rx_word_cdc.sv
design/rx_stream_out.sv
design/tx_word_stage.sv
design/spi_slave_top.sv
dv/spi_slave_assertions.sv
dv/spi_slave_tb.sv

//--- Makefile
# Verilator build, run and lint for the SPI slave port

VERILATOR  ?= verilator
FILELIST   ?= spi_slave.f
TOP        ?= spi_slave_tb
RTL_TOP    ?= spi_slave_top
BUILD_DIR  ?= obj_dir
TIMESCALE  ?= 1ns/100ps
VFLAGS     ?=
LINT_FLAGS ?=
SIM_ARGS   ?= +verilator+error+limit+100
PASS_TEXT  ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary --timing --assert -j 0 --timescale $(TIMESCALE) \
		--top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST) $(VFLAGS)

run: build
	@out="$$($(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale $(TIMESCALE) \
		--top-module $(RTL_TOP) -f $(FILELIST) $(LINT_FLAGS)

clean:
	rm -rf $(BUILD_DIR)
